// File: build.f
+incdir+common
+incdir+testbench
common/mem_ctrl_pkg.sv
design/memory_bank.sv
design/boot_rom.sv
memory_arbiter/rr_grant.sv
memory_arbiter/memory_arbiter.sv
design/memory_controller.sv
testbench/memory_controller_tb.sv

// File: common/mem_ctrl_cfg.svh
// memory controller sizes: word, address, bank, boot ROM and client counts
`ifndef MEM_CTRL_CFG_SVH
`define MEM_CTRL_CFG_SVH

// data word carried by every client and bank
`define MC_DATA_BITS 16

// full client address, top bits pick the bank
`define MC_ADDR_BITS 16

// four single-port banks
`define MC_BANK_COUNT 4
`define MC_BANK_ADDR_BITS 14

// boot ROM overlays the first 256 words of bank 0
`define MC_ROM_ADDR_BITS 8

// sprite, bg0, bg1, ov, flash, audio, cpu
`define MC_CLIENT_COUNT 7

`endif

// File: common/mem_ctrl_pkg.sv
// memory controller types: client index and request / bank access structs
`default_nettype none

`include "mem_ctrl_cfg.svh"

package mem_ctrl_pkg;

	// client slots, order also sets the starting rotation
	typedef enum logic [2:0] {
		cl_sprite = 3'd0,	// sprite engine, read only
		cl_bg0    = 3'd1,	// background 0, read only
		cl_bg1    = 3'd2,	// background 1, read only
		cl_ov     = 3'd3,	// overlay, read only
		cl_fl     = 3'd4,	// flash loader, write only
		cl_au     = 3'd5,	// audio, read only
		cl_cpu    = 3'd6	// cpu, read and write
	} client_e;

	// one client request as held while valid is high
	typedef struct packed {
		logic [`MC_ADDR_BITS-1:0] addr;		// bank select in the top bits
		logic [`MC_DATA_BITS-1:0] wdata;	// don't care on reads
		logic                     wr;		// write request
	} client_req_t;

	// access presented to one bank in one cycle
	typedef struct packed {
		logic [`MC_BANK_ADDR_BITS-1:0] addr;	// word inside the bank
		logic [`MC_DATA_BITS-1:0]      wdata;	// write word
		logic                          wr;		// write strobe
	} bank_acc_t;

endpackage

`default_nettype wire

// File: design/boot_rom.sv
// boot ROM, fixed eight-word stub at the base and zero above it
`default_nettype none

`include "mem_ctrl_cfg.svh"

module boot_rom (
	input  logic                         CLK,
	input  logic [`MC_ROM_ADDR_BITS-1:0] addr,	// cpu address low byte
	output logic [`MC_DATA_BITS-1:0]     rdata	// word one cycle later
);

	// looked up every cycle so the word is ready with the cpu strobe
	always_ff @(posedge CLK) begin
		case (addr)
			8'h00: begin
				rdata <= 16'h3C00;	// load r0 low
			end
			8'h01: begin
				rdata <= 16'h3D01;	// load r1
			end
			8'h02: begin
				rdata <= 16'h4E12;
			end
			8'h03: begin
				rdata <= 16'h5F00;
			end
			8'h04: begin
				rdata <= 16'h2A34;	// copy loop
			end
			8'h05: begin
				rdata <= 16'h1B00;
			end
			8'h06: begin
				rdata <= 16'h7000;	// jump to loaded image
			end
			8'h07: begin
				rdata <= 16'hF000;	// halt
			end
			default: begin
				rdata <= '0;	// rest of the page reads blank
			end
		endcase
	end

endmodule

`default_nettype wire

// File: design/memory_bank.sv
// single-port RAM bank, synchronous write and registered read-first data
`default_nettype none

`include "mem_ctrl_cfg.svh"

module memory_bank #(
	parameter int DATA_BITS = `MC_DATA_BITS,
	parameter int ADDR_BITS = `MC_BANK_ADDR_BITS
) (
	input  logic                    CLK,
	input  mem_ctrl_pkg::bank_acc_t acc,	// address, write word, strobe
	output logic [DATA_BITS-1:0]    rdata	// word at the address of last cycle
);

	localparam int DEPTH = 2 ** ADDR_BITS;

	logic [DATA_BITS-1:0] mem [DEPTH];	// storage, contents undefined at start

	// write port
	always_ff @(posedge CLK) begin
		if (acc.wr) begin
			mem[acc.addr] <= acc.wdata;	// lands at the grant edge
		end
	end

	// read port runs every cycle whether granted or not
	// old contents come out when the same word is written
	always_ff @(posedge CLK) begin
		rdata <= mem[acc.addr];		// read-first
	end

	// a write needs a known address
	a_wr_addr_known: assert property (@(posedge CLK)
		acc.wr |-> !$isunknown(acc.addr));

endmodule

`default_nettype wire

// File: design/memory_controller.sv
// memory controller top, four banks behind the arbiter plus the cpu boot ROM overlay
`default_nettype none

`include "mem_ctrl_cfg.svh"

module memory_controller (
	input  logic                     CLK,
	input  logic                     rst_n,

	// sprite engine
	input  logic [`MC_ADDR_BITS-1:0] sprite_memory_address,
	output logic [`MC_DATA_BITS-1:0] sprite_memory_data,
	input  logic                     sprite_rvalid,
	output logic                     sprite_rready,

	// background 0
	input  logic [`MC_ADDR_BITS-1:0] bg0_memory_address,
	output logic [`MC_DATA_BITS-1:0] bg0_memory_data,
	input  logic                     bg0_rvalid,
	output logic                     bg0_rready,

	// background 1
	input  logic [`MC_ADDR_BITS-1:0] bg1_memory_address,
	output logic [`MC_DATA_BITS-1:0] bg1_memory_data,
	input  logic                     bg1_rvalid,
	output logic                     bg1_rready,

	// overlay
	input  logic [`MC_ADDR_BITS-1:0] ov_memory_address,
	output logic [`MC_DATA_BITS-1:0] ov_memory_data,
	input  logic                     ov_rvalid,
	output logic                     ov_rready,

	// flash loader, writes only
	input  logic [`MC_ADDR_BITS-1:0] fl_memory_address,
	input  logic [`MC_DATA_BITS-1:0] fl_memory_data,
	input  logic                     fl_wvalid,
	output logic                     fl_wready,

	// audio
	input  logic [`MC_ADDR_BITS-1:0] au_memory_address,
	output logic [`MC_DATA_BITS-1:0] au_memory_data,
	input  logic                     au_rvalid,
	output logic                     au_rready,

	// cpu
	input  logic [`MC_ADDR_BITS-1:0] cpu_memory_address,
	input  logic [`MC_DATA_BITS-1:0] cpu_memory_data_in,
	output logic [`MC_DATA_BITS-1:0] cpu_memory_data,
	input  logic                     cpu_valid,
	input  logic                     cpu_wr,		// cpu write
	output logic                     cpu_ready
);

	mem_ctrl_pkg::client_req_t   creq [`MC_CLIENT_COUNT];	// packed client requests
	logic [`MC_CLIENT_COUNT-1:0] cvalid;
	logic [`MC_CLIENT_COUNT-1:0] cready;
	logic [`MC_DATA_BITS-1:0]    crdata [`MC_CLIENT_COUNT];
	mem_ctrl_pkg::bank_acc_t     bank_acc [`MC_BANK_COUNT];
	logic [`MC_DATA_BITS-1:0]    bank_rdata [`MC_BANK_COUNT];
	logic [`MC_DATA_BITS-1:0]    rom_data;		// ROM word for last cpu address
	logic                        rom_hit_q;		// last cpu address was in page 0

	// client ports into arbiter slots
	always_comb begin
		creq[mem_ctrl_pkg::cl_sprite] = '{addr: sprite_memory_address, wdata: '0, wr: 1'b0};
		creq[mem_ctrl_pkg::cl_bg0]    = '{addr: bg0_memory_address, wdata: '0, wr: 1'b0};
		creq[mem_ctrl_pkg::cl_bg1]    = '{addr: bg1_memory_address, wdata: '0, wr: 1'b0};
		creq[mem_ctrl_pkg::cl_ov]     = '{addr: ov_memory_address, wdata: '0, wr: 1'b0};
		creq[mem_ctrl_pkg::cl_fl]     = '{addr: fl_memory_address, wdata: fl_memory_data,
			wr: 1'b1};
		creq[mem_ctrl_pkg::cl_au]     = '{addr: au_memory_address, wdata: '0, wr: 1'b0};
		creq[mem_ctrl_pkg::cl_cpu]    = '{addr: cpu_memory_address, wdata: cpu_memory_data_in,
			wr: cpu_wr};
		cvalid[mem_ctrl_pkg::cl_sprite] = sprite_rvalid;
		cvalid[mem_ctrl_pkg::cl_bg0]    = bg0_rvalid;
		cvalid[mem_ctrl_pkg::cl_bg1]    = bg1_rvalid;
		cvalid[mem_ctrl_pkg::cl_ov]     = ov_rvalid;
		cvalid[mem_ctrl_pkg::cl_fl]     = fl_wvalid;
		cvalid[mem_ctrl_pkg::cl_au]     = au_rvalid;
		cvalid[mem_ctrl_pkg::cl_cpu]    = cpu_valid;
	end

	// strobes and read words back out
	assign sprite_rready      = cready[mem_ctrl_pkg::cl_sprite];
	assign sprite_memory_data = crdata[mem_ctrl_pkg::cl_sprite];
	assign bg0_rready         = cready[mem_ctrl_pkg::cl_bg0];
	assign bg0_memory_data    = crdata[mem_ctrl_pkg::cl_bg0];
	assign bg1_rready         = cready[mem_ctrl_pkg::cl_bg1];
	assign bg1_memory_data    = crdata[mem_ctrl_pkg::cl_bg1];
	assign ov_rready          = cready[mem_ctrl_pkg::cl_ov];
	assign ov_memory_data     = crdata[mem_ctrl_pkg::cl_ov];
	assign fl_wready          = cready[mem_ctrl_pkg::cl_fl];
	assign au_rready          = cready[mem_ctrl_pkg::cl_au];
	assign au_memory_data     = crdata[mem_ctrl_pkg::cl_au];
	assign cpu_ready          = cready[mem_ctrl_pkg::cl_cpu];

	// ROM shadows bank 0 for cpu reads only, writes still reach the RAM
	always_ff @(posedge CLK) begin
		rom_hit_q <= (cpu_memory_address[`MC_ADDR_BITS-1:`MC_ROM_ADDR_BITS] == '0);
	end

	assign cpu_memory_data = rom_hit_q ? rom_data : crdata[mem_ctrl_pkg::cl_cpu];

	boot_rom rom0 (
		.CLK   (CLK),
		.addr  (cpu_memory_address[`MC_ROM_ADDR_BITS-1:0]),
		.rdata (rom_data)
	);

	for (genvar b = 0; b < `MC_BANK_COUNT; b++) begin : g_bank
		memory_bank #(
			.DATA_BITS (`MC_DATA_BITS),
			.ADDR_BITS (`MC_BANK_ADDR_BITS)
		) mb (
			.CLK   (CLK),
			.acc   (bank_acc[b]),
			.rdata (bank_rdata[b])
		);
	end

	memory_arbiter ma0 (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.req        (creq),
		.valid      (cvalid),
		.ready      (cready),
		.rdata      (crdata),
		.bank_acc   (bank_acc),
		.bank_rdata (bank_rdata)
	);

endmodule

`default_nettype wire

// File: memory_arbiter/memory_arbiter.sv
// memory arbiter, routes seven clients onto four banks and returns strobes and data
`default_nettype none

`include "mem_ctrl_cfg.svh"

module memory_arbiter (
	input  logic                            CLK,
	input  logic                            rst_n,

	// client side, indexed by client_e
	input  mem_ctrl_pkg::client_req_t       req [`MC_CLIENT_COUNT],
	input  logic [`MC_CLIENT_COUNT-1:0]     valid,	// request held until ready
	output logic [`MC_CLIENT_COUNT-1:0]     ready,	// one-cycle done pulse
	output logic [`MC_DATA_BITS-1:0]        rdata [`MC_CLIENT_COUNT],

	// bank side
	output mem_ctrl_pkg::bank_acc_t         bank_acc [`MC_BANK_COUNT],
	input  logic [`MC_DATA_BITS-1:0]        bank_rdata [`MC_BANK_COUNT]
);

	localparam int CLIENTS  = `MC_CLIENT_COUNT;
	localparam int BANKS    = `MC_BANK_COUNT;
	localparam int SEL_BITS = $clog2(BANKS);

	logic [SEL_BITS-1:0] client_bank [CLIENTS];	// bank each client addresses
	logic [CLIENTS-1:0]  wr_ok;				// write allowed and requested
	logic [CLIENTS-1:0]  bank_req [BANKS];	// requests split per bank
	logic [CLIENTS-1:0]  gnt [BANKS];		// picker outputs
	logic [CLIENTS-1:0]  served;			// clients granted this cycle
	logic [SEL_BITS-1:0] rsel [CLIENTS];	// bank that served the client

	// address decode and direction guard
	// read-only clients never write, flash always writes
	always_comb begin
		for (int c = 0; c < CLIENTS; c++) begin
			client_bank[c] = req[c].addr[`MC_ADDR_BITS-1 -: SEL_BITS];	// bits 15:14
			case (mem_ctrl_pkg::client_e'(c))
				mem_ctrl_pkg::cl_fl: begin
					wr_ok[c] = 1'b1;	// flash has no read path
				end
				mem_ctrl_pkg::cl_cpu: begin
					wr_ok[c] = req[c].wr;
				end
				default: begin
					wr_ok[c] = 1'b0;	// stray wr bit dropped
				end
			endcase
		end
	end

	// each valid request shows up at exactly one bank
	always_comb begin
		for (int b = 0; b < BANKS; b++) begin
			for (int c = 0; c < CLIENTS; c++) begin
				bank_req[b][c] = valid[c] && (client_bank[c] == SEL_BITS'(b));
			end
		end
	end

	for (genvar b = 0; b < BANKS; b++) begin : g_bank
		// own rotation per bank, so banks never wait on each other
		rr_grant #(
			.N(CLIENTS)
		) u_pick (
			.CLK   (CLK),
			.rst_n (rst_n),
			.req   (bank_req[b]),
			.grant (gnt[b])
		);

		// one-hot mux of the winner onto the bank
		always_comb begin
			bank_acc[b] = '0;	// idle bank reads word 0, harmless
			for (int c = 0; c < CLIENTS; c++) begin
				if (gnt[b][c]) begin
					bank_acc[b].addr  = req[c].addr[`MC_BANK_ADDR_BITS-1:0];
					bank_acc[b].wdata = req[c].wdata;
					bank_acc[b].wr    = wr_ok[c];
				end
			end
		end

		// picker and mux must agree on a single winner
		a_one_grant: assert property (@(posedge CLK) disable iff (!rst_n)
			$onehot0(gnt[b]));
	end

	// collapse the per-bank grants onto the clients
	always_comb begin
		served = '0;
		for (int b = 0; b < BANKS; b++) begin
			served = served | gnt[b];
		end
	end

	// ready follows the grant by one cycle, with the bank read word
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			ready <= '0;
		end else begin
			ready <= served;
		end
	end

	// bank index kept alongside so the read word can be steered back
	always_ff @(posedge CLK) begin
		for (int c = 0; c < CLIENTS; c++) begin
			rsel[c] <= client_bank[c];
		end
	end

	// return path, only meaningful while ready is high
	always_comb begin
		for (int c = 0; c < CLIENTS; c++) begin
			rdata[c] = bank_rdata[rsel[c]];
		end
	end

	// no strobe for a client that was not asking in the grant cycle
	a_ready_had_valid: assert property (@(posedge CLK) disable iff (!rst_n)
		(ready & ~$past(valid)) == '0);

endmodule

`default_nettype wire

// File: memory_arbiter/rr_grant.sv
// rotating-priority grant picker for the clients of one bank
`default_nettype none

`include "mem_ctrl_cfg.svh"

module rr_grant #(
	parameter int N = `MC_CLIENT_COUNT
) (
	input  logic         CLK,
	input  logic         rst_n,
	input  logic [N-1:0] req,	// clients wanting this bank now
	output logic [N-1:0] grant	// one-hot pick, zero when idle
);

	localparam int PTR_BITS = $clog2(N);

	logic [PTR_BITS-1:0] ptr;	// first client to look at this cycle
	logic [PTR_BITS-1:0] win;	// index of the picked client

	// scan from ptr upwards and wrap, first requester wins
	always_comb begin
		int   idx;
		logic found;
		grant = '0;
		win   = ptr;
		found = 1'b0;
		for (int i = 0; i < N; i++) begin
			idx = int'(ptr) + i;
			if (idx >= N) begin
				idx = idx - N;	// wrap past the last client
			end
			if (!found && req[idx]) begin
				grant[idx] = 1'b1;
				win        = PTR_BITS'(idx);
				found      = 1'b1;
			end
		end
	end

	// winner drops to lowest priority for the next pick
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			ptr <= '0;	// sprite first
		end else if (|grant) begin
			ptr <= (win == PTR_BITS'(N - 1)) ? '0 : win + 1'b1;
		end
	end

	a_grant_onehot: assert property (@(posedge CLK) disable iff (!rst_n)
		$onehot0(grant));

	a_grant_in_req: assert property (@(posedge CLK) disable iff (!rst_n)
		(grant & ~req) == '0);

endmodule

`default_nettype wire

// File: testbench/memory_controller_tests.svh
// directed memory controller tests, included into the testbench module

task automatic test_cpu_banks();
	logic [15:0] addr [8];
	logic [15:0] rdata;
	logic        got;
	start_test("cpu_banks");
	for (int i = 0; i < 8; i++) begin
		addr[i] = {2'(i / 2), 14'($urandom_range(14'h3FFF, 14'h0100))};	// two per bank
		cpu_access(1'b1, addr[i], 16'($urandom), rdata, got);
	end
	for (int i = 0; i < 8; i++) begin
		cpu_access(1'b0, addr[i], '0, rdata, got);
		check_eq($sformatf("cpu read %h", addr[i]), model[addr[i]], rdata);
	end
	finish_test();
endtask

task automatic test_boot_rom();
	logic [15:0] stub [8] = '{16'h3C00, 16'h3D01, 16'h4E12, 16'h5F00,
		16'h2A34, 16'h1B00, 16'h7000, 16'hF000};
	logic [15:0] addr;
	logic [15:0] rdata;
	logic        got;
	start_test("boot_rom");
	for (int i = 0; i < 8; i++) begin
		cpu_access(1'b0, 16'(i), '0, rdata, got);
		check_eq($sformatf("rom stub %h", i), stub[i], rdata);
	end
	for (int i = 0; i < 12; i++) begin
		addr = 16'($urandom_range(16'h00FF, 16'h0008));	// blank part of page 0
		cpu_access(1'b0, addr, '0, rdata, got);
		check_eq($sformatf("rom blank %h", addr), 16'h0000, rdata);
	end
	cpu_access(1'b1, 16'h0003, 16'($urandom), rdata, got);	// lands under the ROM
	cpu_access(1'b0, 16'h0003, '0, rdata, got);
	check_eq("rom shadow cpu", stub[3], rdata);
	reader_read(0, 16'h0003, rdata);
	check_eq("rom shadow sprite", model[16'h0003], rdata);
	finish_test();
endtask

task automatic test_flash_readers();
	logic [15:0] base;
	logic [15:0] rdata;
	start_test("flash_readers");
	base = 16'h4200 + 16'($urandom & 32'h0FF0);	// bank 1
	for (int i = 0; i < 5; i++) begin
		fl_write(base + 16'(i), 16'($urandom));
	end
	for (int r = 0; r < READERS; r++) begin
		for (int i = 0; i < 5; i++) begin
			reader_read(r, base + 16'(i), rdata);
			check_eq({"flash block ", reader_name[r]}, model[base + 16'(i)], rdata);
		end
	end
	finish_test();
endtask

task automatic test_parallel_banks();
	logic [15:0] addr [4];
	start_test("parallel_banks");
	for (int b = 0; b < 4; b++) begin
		addr[b] = {2'(b), 14'($urandom_range(14'h3FFF, 14'h0100))};
		fl_write(addr[b], 16'($urandom));
	end
	for (int b = 0; b < 4; b++) begin
		rd_addr[b] = addr[b];	// reader b to bank b
	end
	rd_valid[3:0] = 4'hF;
	@(negedge CLK);	// one grant cycle, no contention
	check_eq("parallel ready", 16'h000F, {12'h000, rd_ready[3:0]});
	for (int b = 0; b < 4; b++) begin
		check_eq({"parallel data ", reader_name[b]}, model[addr[b]], rd_data[b]);
	end
	rd_valid = '0;
	finish_test();
endtask

task automatic test_fairness();
	logic [15:0] base;
	int          count [READERS];
	int          since [READERS];	// other grants seen while waiting
	int          total;
	int          cycles;
	int          grants_now;
	start_test("fairness");
	base = 16'h8000 + 16'($urandom & 32'h3FE0);	// bank 2
	for (int i = 0; i < 16; i++) begin
		fl_write(base + 16'(i), 16'($urandom));
	end
	for (int r = 0; r < READERS; r++) begin
		rd_addr[r] = base + 16'($urandom_range(15, 0));
		count[r] = 0;
		since[r] = 0;
	end
	rd_valid = '1;
	total = 0;
	cycles = 0;
	while (total < 35 && cycles < 200) begin
		@(negedge CLK);
		cycles++;
		grants_now = $countones(rd_ready);
		for (int r = 0; r < READERS; r++) begin
			if (rd_ready[r]) begin
				check_eq({"fair data ", reader_name[r]}, model[rd_addr[r]], rd_data[r]);
				if (since[r] > 7) begin
					$display("%s waited %0d grants for bank 2", reader_name[r], since[r]);
					errors++;
				end
				count[r]++;
				since[r] = 0;
				total++;
				rd_addr[r] = base + 16'($urandom_range(15, 0));	// next request at once
			end else begin
				since[r] += grants_now;
			end
		end
	end
	rd_valid = '0;
	if (total < 35) begin
		$display("bank 2 gave only %0d grants in %0d cycles", total, cycles);
		errors++;
	end
	for (int r = 0; r < READERS; r++) begin
		if (count[r] < 6) begin
			$display("%s got only %0d of %0d grants", reader_name[r], count[r], total);
			errors++;
		end
	end
	finish_test();
endtask

task automatic test_reset();
	start_test("reset");
	rd_valid = '1;		// reads pending as reset hits
	cpu_valid = 1'b1;
	rst_n = 1'b0;
	for (int i = 0; i < 8; i++) begin
		@(negedge CLK);
		check_eq("ready in reset", 16'h0000, {9'h000, cpu_ready, fl_wready, rd_ready});
	end
	rd_valid = '0;
	cpu_valid = 1'b0;
	rst_n = 1'b1;
	for (int i = 0; i < 10; i++) begin
		@(negedge CLK);	// idle, nobody asking
		check_eq("ready after reset", 16'h0000, {9'h000, cpu_ready, fl_wready, rd_ready});
	end
	rd_valid = '1;	// all readers on bank 2, rotation starts at sprite
	@(negedge CLK);
	check_eq("first grant after reset", 16'h0001, {11'h000, rd_ready});
	rd_valid = '0;
	finish_test();
endtask

// File: testbench/memory_controller_tb.sv
// memory controller testbench, clock, reset, memory model and client access tasks
`default_nettype none

`include "mem_ctrl_cfg.svh"

module memory_controller_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int READERS = 5;	// sprite, bg0, bg1, ov, au
	localparam int WAIT_LIMIT = 50;

	logic                     CLK;
	logic                     rst_n;
	logic [`MC_ADDR_BITS-1:0] rd_addr [READERS];
	logic [READERS-1:0]       rd_valid;
	wire  [READERS-1:0]       rd_ready;
	logic [`MC_DATA_BITS-1:0] rd_data [READERS];	// gathered reader words
	wire  [`MC_DATA_BITS-1:0] sprite_data, bg0_data, bg1_data, ov_data, au_data;
	wire                      sprite_rdy, bg0_rdy, bg1_rdy, ov_rdy, au_rdy;
	logic [`MC_ADDR_BITS-1:0] fl_addr;
	logic [`MC_DATA_BITS-1:0] fl_wdata;
	logic                     fl_wvalid;
	wire                      fl_wready;
	logic [`MC_ADDR_BITS-1:0] cpu_addr;
	logic [`MC_DATA_BITS-1:0] cpu_wdata;
	wire  [`MC_DATA_BITS-1:0] cpu_rdata;
	logic                     cpu_valid;
	logic                     cpu_wr;
	wire                      cpu_ready;

	logic [`MC_DATA_BITS-1:0] model [logic [`MC_ADDR_BITS-1:0]];	// acknowledged writes
	string reader_name [READERS] = '{"sprite", "bg0", "bg1", "ov", "au"};
	string test_name;		// test now running
	int    errors;
	int    errors_at_start;	// error count when the running test began
	int    tests_passed;
	int    tests_failed;

	assign rd_ready = {au_rdy, ov_rdy, bg1_rdy, bg0_rdy, sprite_rdy};

	always_comb begin
		rd_data[0] = sprite_data;
		rd_data[1] = bg0_data;
		rd_data[2] = bg1_data;
		rd_data[3] = ov_data;
		rd_data[4] = au_data;
	end

	always #5 CLK = ~CLK;	// 100 MHz

	memory_controller dut0 (
		.CLK (CLK), .rst_n (rst_n),
		.sprite_memory_address (rd_addr[0]), .sprite_memory_data (sprite_data),
		.sprite_rvalid (rd_valid[0]), .sprite_rready (sprite_rdy),
		.bg0_memory_address (rd_addr[1]), .bg0_memory_data (bg0_data),
		.bg0_rvalid (rd_valid[1]), .bg0_rready (bg0_rdy),
		.bg1_memory_address (rd_addr[2]), .bg1_memory_data (bg1_data),
		.bg1_rvalid (rd_valid[2]), .bg1_rready (bg1_rdy),
		.ov_memory_address (rd_addr[3]), .ov_memory_data (ov_data),
		.ov_rvalid (rd_valid[3]), .ov_rready (ov_rdy),
		.fl_memory_address (fl_addr), .fl_memory_data (fl_wdata),
		.fl_wvalid (fl_wvalid), .fl_wready (fl_wready),
		.au_memory_address (rd_addr[4]), .au_memory_data (au_data),
		.au_rvalid (rd_valid[4]), .au_rready (au_rdy),
		.cpu_memory_address (cpu_addr), .cpu_memory_data_in (cpu_wdata),
		.cpu_memory_data (cpu_rdata), .cpu_valid (cpu_valid),
		.cpu_wr (cpu_wr), .cpu_ready (cpu_ready)
	);

	task automatic check_eq(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (exp !== act) begin
			$display("[ERROR] %s %s expected %h actual %h", test_name, name, exp, act);
			errors++;
		end
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (8) @(negedge CLK);	// eight cycles low
		rst_n = 1'b1;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic finish_test();
		if (errors == errors_at_start) begin
			tests_passed++;
			$display("test %s passed", test_name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	// called at a falling edge, returns at the falling edge that saw ready
	task automatic cpu_access(input logic wr, input logic [15:0] addr, input logic [15:0] wdata,
		output logic [15:0] rdata, output logic got);
		int waited;
		got = 1'b0;
		rdata = '0;
		waited = 0;
		cpu_addr = addr;
		cpu_wdata = wdata;
		cpu_wr = wr;
		cpu_valid = 1'b1;
		while (!got && waited < WAIT_LIMIT) begin
			@(negedge CLK);
			waited++;
			if (cpu_ready) begin
				got = 1'b1;
				rdata = cpu_rdata;	// same cycle as the strobe
			end
		end
		cpu_valid = 1'b0;	// drop before the next edge, no repeat
		cpu_wr = 1'b0;
		if (!got) begin
			$display("cpu got no ready within %0d cycles at address %h", WAIT_LIMIT, addr);
			errors++;
		end else if (wr) begin
			model[addr] = wdata;
		end
	endtask

	task automatic fl_write(input logic [15:0] addr, input logic [15:0] wdata);
		int   waited;
		logic got;
		waited = 0;
		got = 1'b0;
		fl_addr = addr;
		fl_wdata = wdata;
		fl_wvalid = 1'b1;
		while (!got && waited < WAIT_LIMIT) begin
			@(negedge CLK);
			waited++;
			got = fl_wready;
		end
		fl_wvalid = 1'b0;
		if (!got) begin
			$display("flash got no ready within %0d cycles at address %h", WAIT_LIMIT, addr);
			errors++;
		end else begin
			model[addr] = wdata;
		end
	endtask

	task automatic reader_read(input int r, input logic [15:0] addr, output logic [15:0] rdata);
		int   waited;
		logic got;
		waited = 0;
		got = 1'b0;
		rdata = '0;
		rd_addr[r] = addr;
		rd_valid[r] = 1'b1;
		while (!got && waited < WAIT_LIMIT) begin
			@(negedge CLK);
			waited++;
			if (rd_ready[r]) begin
				got = 1'b1;
				rdata = rd_data[r];
			end
		end
		rd_valid[r] = 1'b0;
		if (!got) begin
			$display("%s got no ready within %0d cycles at address %h",
				reader_name[r], WAIT_LIMIT, addr);
			errors++;
		end
	endtask

	`include "memory_controller_tests.svh"

	initial begin
		void'($urandom(32'h3898c0c7));	// one seed for the whole run
		CLK = 1'b0;
		rst_n = 1'b0;
		rd_valid = '0;
		for (int r = 0; r < READERS; r++) begin
			rd_addr[r] = '0;
		end
		fl_addr = '0;
		fl_wdata = '0;
		fl_wvalid = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		cpu_valid = 1'b0;
		cpu_wr = 1'b0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		apply_reset();
		test_cpu_banks();
		test_boot_rom();
		test_flash_readers();
		test_parallel_banks();
		test_fairness();
		test_reset();
		$display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
